// File: boot_rom.hex
// boot image, one 32-bit word per line in hex, word 0 first
00000093
00000113
800001b7
00018213
00100293
00520023
00a00313
00628333
fff30313
fe031ce3
0001a023
00000013
00000013
00000013
0000006f
5a5aa5a5

// File: design/boot_ctrl.sv
`timescale 1ns/1ps

module boot_ctrl import mem_cfg_pkg::*; import boot_pkg::*; (
   input  logic                    i_clk,
   input  logic                    i_rst_n,
   output logic                    o_boot,
   output logic                    o_cpu_reset,
   input  logic                    i_reg_valid,
   input  logic [DATA_W-1:0]       i_reg_wdata,
   input  logic [STRB_W-1:0]       i_reg_wstrb,
   output logic [DATA_W-1:0]       o_reg_rdata,
   output logic                    o_reg_ready,
   output logic                    o_bw_valid,
   output logic [SRAM_WORD_AW-1:0] o_bw_addr,
   output logic [DATA_W-1:0]       o_bw_wdata,
   output logic [STRB_W-1:0]       o_bw_wstrb,
   input  logic                    i_bw_ready
);

   localparam int IDX_W = BOOTROM_ADDR_W - 2;
   localparam int CNT_W = $clog2(RST_PULSE_CYC + 1);
   localparam logic [SRAM_WORD_AW-1:0] BOOT_BASE = SRAM_WORD_AW'(BOOT_OFFSET_W);

   logic [DATA_W-1:0] rom [BOOT_WORDS];
   boot_state_t       state;
   logic [IDX_W-1:0]  idx;
   logic [CNT_W-1:0]  pulse_cnt;
   logic              reg_wr;

   initial begin
      $readmemh("boot_rom.hex", rom);
   end

   // boot image word idx goes to the top region
   assign o_bw_addr = BOOT_BASE + SRAM_WORD_AW'(idx);
   assign o_bw_wdata = rom[idx];
   assign o_bw_wstrb = {STRB_W{o_bw_valid}};

   // register only holds the boot bit
   assign o_reg_rdata = {{(DATA_W-1){1'b0}}, o_boot};
   assign reg_wr = i_reg_valid & ~o_reg_ready & i_reg_wstrb[0];

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state <= COPY;
         idx <= '0;
         pulse_cnt <= '0;
         o_bw_valid <= 1'b0;
         o_boot <= 1'b1;
         o_cpu_reset <= 1'b1;
         o_reg_ready <= 1'b0;
      end else begin
         o_reg_ready <= i_reg_valid & ~o_reg_ready;
         case (state)
            COPY: begin
               o_bw_valid <= 1'b1;
               if (o_bw_valid && i_bw_ready) begin
                  if (idx == IDX_W'(BOOT_WORDS - 1)) begin
                     // image done, let the cpu run the boot code
                     o_bw_valid <= 1'b0;
                     o_cpu_reset <= 1'b0;
                     state <= RUN_BOOT;
                  end else begin
                     idx <= idx + 1'b1;
                  end
               end
            end
            RUN_BOOT: begin
               if (reg_wr && !i_reg_wdata[0]) begin
                  o_boot <= 1'b0;
                  o_cpu_reset <= 1'b1;
                  pulse_cnt <= '0;
                  state <= RST_PULSE;
               end
            end
            RST_PULSE: begin
               pulse_cnt <= pulse_cnt + 1'b1;
               if (pulse_cnt == CNT_W'(RST_PULSE_CYC - 1)) begin
                  o_cpu_reset <= 1'b0;
                  state <= RUN;
               end
            end
            default: begin
               // normal operation, nothing left to do
               state <= RUN;
            end
         endcase
      end
   end

endmodule

// File: design/boot_pkg.sv
package boot_pkg;

   // boot controller sequence
   typedef enum logic [1:0] {
      COPY,
      RUN_BOOT,
      RST_PULSE,
      RUN
   } boot_state_t;

   // who owns the sram instruction port
   typedef enum logic {
      SRC_BOOT,
      SRC_CPU
   } merge_src_t;

   // cpu reset length when leaving boot mode, in cycles
   localparam int RST_PULSE_CYC = 4;

endpackage

// File: design/bus_merge.sv
`timescale 1ns/1ps

module bus_merge import mem_cfg_pkg::*; import boot_pkg::*; (
   input  logic                    i_clk,
   input  logic                    i_rst_n,
   input  logic                    i_bw_valid,
   input  logic [SRAM_WORD_AW-1:0] i_bw_addr,
   input  logic [DATA_W-1:0]       i_bw_wdata,
   input  logic [STRB_W-1:0]       i_bw_wstrb,
   output logic                    o_bw_ready,
   input  logic                    i_cpu_valid,
   input  logic [SRAM_WORD_AW-1:0] i_cpu_addr,
   input  logic [DATA_W-1:0]       i_cpu_wdata,
   input  logic [STRB_W-1:0]       i_cpu_wstrb,
   output logic [DATA_W-1:0]       o_cpu_rdata,
   output logic                    o_cpu_ready,
   output logic                    o_mem_valid,
   output logic [SRAM_WORD_AW-1:0] o_mem_addr,
   output logic [DATA_W-1:0]       o_mem_wdata,
   output logic [STRB_W-1:0]       o_mem_wstrb,
   input  logic [DATA_W-1:0]       i_mem_rdata,
   input  logic                    i_mem_ready
);

   merge_src_t grant;
   merge_src_t sel;
   logic       busy;

   // boot writer wins a fresh arbitration, a held grant is kept
   always_comb begin
      if (busy) begin
         sel = grant;
      end else if (i_bw_valid) begin
         sel = SRC_BOOT;
      end else begin
         sel = SRC_CPU;
      end
   end

   assign o_mem_valid = (sel == SRC_BOOT) ? i_bw_valid : i_cpu_valid;
   assign o_mem_addr = (sel == SRC_BOOT) ? i_bw_addr : i_cpu_addr;
   assign o_mem_wdata = (sel == SRC_BOOT) ? i_bw_wdata : i_cpu_wdata;
   assign o_mem_wstrb = (sel == SRC_BOOT) ? i_bw_wstrb : i_cpu_wstrb;

   assign o_bw_ready = i_mem_ready & (sel == SRC_BOOT);
   assign o_cpu_ready = i_mem_ready & (sel == SRC_CPU);
   assign o_cpu_rdata = i_mem_rdata;

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         busy <= 1'b0;
         grant <= SRC_BOOT;
      end else if (!busy && (i_bw_valid || i_cpu_valid)) begin
         busy <= 1'b1;
         grant <= sel;
      end else if (busy && i_mem_ready) begin
         busy <= 1'b0;
      end
   end

endmodule

// File: design/bus_split.sv
`timescale 1ns/1ps

module bus_split import mem_cfg_pkg::*; (
   input  logic              i_clk,
   input  logic              i_rst_n,
   input  logic              i_dbus_valid,
   input  logic [ADDR_W-1:0] i_dbus_addr,
   input  logic [DATA_W-1:0] i_dbus_wdata,
   input  logic [STRB_W-1:0] i_dbus_wstrb,
   output logic [DATA_W-1:0] o_dbus_rdata,
   output logic              o_dbus_ready,
   output logic              o_mem_valid,
   output logic [ADDR_W-1:0] o_mem_addr,
   output logic [DATA_W-1:0] o_mem_wdata,
   output logic [STRB_W-1:0] o_mem_wstrb,
   input  logic [DATA_W-1:0] i_mem_rdata,
   input  logic              i_mem_ready,
   output logic              o_reg_valid,
   output logic [DATA_W-1:0] o_reg_wdata,
   output logic [STRB_W-1:0] o_reg_wstrb,
   input  logic [DATA_W-1:0] i_reg_rdata,
   input  logic              i_reg_ready
);

   logic sel_reg;
   logic pend;
   logic pend_reg;

   assign sel_reg = i_dbus_addr[REG_SEL_BIT];

   // request goes to one target only
   assign o_mem_valid = i_dbus_valid & ~sel_reg;
   assign o_mem_addr = i_dbus_addr;
   assign o_mem_wdata = i_dbus_wdata;
   assign o_mem_wstrb = i_dbus_wstrb;
   assign o_reg_valid = i_dbus_valid & sel_reg;
   assign o_reg_wdata = i_dbus_wdata;
   assign o_reg_wstrb = i_dbus_wstrb;

   // response comes from the target latched at request start
   assign o_dbus_ready = pend & (pend_reg ? i_reg_ready : i_mem_ready);
   assign o_dbus_rdata = pend_reg ? i_reg_rdata : i_mem_rdata;

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pend <= 1'b0;
         pend_reg <= 1'b0;
      end else if (!pend && i_dbus_valid) begin
         pend <= 1'b1;
         pend_reg <= sel_reg;
      end else if (o_dbus_ready) begin
         pend <= 1'b0;
      end
   end

endmodule

// File: design/dual_port_sram.sv
`timescale 1ns/1ps

module dual_port_sram import mem_cfg_pkg::*; (
   input  logic                    i_clk,
   input  logic                    i_i_valid,
   input  logic [SRAM_WORD_AW-1:0] i_i_addr,
   input  logic [DATA_W-1:0]       i_i_wdata,
   input  logic [STRB_W-1:0]       i_i_wstrb,
   output logic [DATA_W-1:0]       o_i_rdata,
   output logic                    o_i_ready,
   input  logic                    i_d_valid,
   input  logic [SRAM_WORD_AW-1:0] i_d_addr,
   input  logic [DATA_W-1:0]       i_d_wdata,
   input  logic [STRB_W-1:0]       i_d_wstrb,
   output logic [DATA_W-1:0]       o_d_rdata,
   output logic                    o_d_ready
);

   logic [DATA_W-1:0]       mem [SRAM_WORDS];

   // port 0 is I, port 1 is D
   logic                    p_valid [2];
   logic [SRAM_WORD_AW-1:0] p_addr [2];
   logic [DATA_W-1:0]       p_wdata [2];
   logic [STRB_W-1:0]       p_wstrb [2];
   logic [DATA_W-1:0]       p_rdata [2];
   logic                    p_ready [2];

   assign p_valid = '{i_i_valid, i_d_valid};
   assign p_addr = '{i_i_addr, i_d_addr};
   assign p_wdata = '{i_i_wdata, i_d_wdata};
   assign p_wstrb = '{i_i_wstrb, i_d_wstrb};

   assign o_i_rdata = p_rdata[0];
   assign o_i_ready = p_ready[0];
   assign o_d_rdata = p_rdata[1];
   assign o_d_ready = p_ready[1];

   // port D is handled last so it wins a same-word write
   always_ff @(posedge i_clk) begin
      for (int p = 0; p < 2; p++) begin
         // ready cycle still sees the held request, skip it
         p_ready[p] <= p_valid[p] & ~p_ready[p];
         if (p_valid[p] && !p_ready[p]) begin
            p_rdata[p] <= mem[p_addr[p]];
            for (int b = 0; b < STRB_W; b++) begin
               if (p_wstrb[p][b]) begin
                  mem[p_addr[p]][8*b +: 8] <= p_wdata[p][8*b +: 8];
               end
            end
         end
      end
   end

endmodule

// File: design/int_mem.sv
`timescale 1ns/1ps

module int_mem import mem_cfg_pkg::*; (
   input  logic              i_clk,
   input  logic              i_rst_n,
   output logic              o_boot,
   output logic              o_cpu_reset,
   input  logic              i_ibus_valid,
   input  logic [ADDR_W-1:0] i_ibus_addr,
   output logic [DATA_W-1:0] o_ibus_rdata,
   output logic              o_ibus_ready,
   input  logic              i_dbus_valid,
   input  logic [ADDR_W-1:0] i_dbus_addr,
   input  logic [DATA_W-1:0] i_dbus_wdata,
   input  logic [STRB_W-1:0] i_dbus_wstrb,
   output logic [DATA_W-1:0] o_dbus_rdata,
   output logic              o_dbus_ready
);

   localparam logic [SRAM_WORD_AW-1:0] BOOT_BASE = SRAM_WORD_AW'(BOOT_OFFSET_W);

   // dbus toward the sram
   logic                    dm_valid;
   logic [ADDR_W-1:0]       dm_addr;
   logic [DATA_W-1:0]       dm_wdata;
   logic [STRB_W-1:0]       dm_wstrb;
   logic [DATA_W-1:0]       dm_rdata;
   logic                    dm_ready;
   logic [SRAM_WORD_AW-1:0] dm_word;

   // dbus toward the boot register
   logic                    reg_valid;
   logic [DATA_W-1:0]       reg_wdata;
   logic [STRB_W-1:0]       reg_wstrb;
   logic [DATA_W-1:0]       reg_rdata;
   logic                    reg_ready;

   // boot write stream
   logic                    bw_valid;
   logic [SRAM_WORD_AW-1:0] bw_addr;
   logic [DATA_W-1:0]       bw_wdata;
   logic [STRB_W-1:0]       bw_wstrb;
   logic                    bw_ready;

   // merged sram instruction port
   logic [SRAM_WORD_AW-1:0] i_word;
   logic                    im_valid;
   logic [SRAM_WORD_AW-1:0] im_addr;
   logic [DATA_W-1:0]       im_wdata;
   logic [STRB_W-1:0]       im_wstrb;
   logic [DATA_W-1:0]       im_rdata;
   logic                    im_ready;

   // boot mode moves both buses up, wrapping in the sram
   assign i_word = i_ibus_addr[SRAM_ADDR_W-1:2] + (o_boot ? BOOT_BASE : '0);
   assign dm_word = dm_addr[SRAM_ADDR_W-1:2] + (o_boot ? BOOT_BASE : '0);

   bus_split i_split (
      .i_clk(i_clk), .i_rst_n(i_rst_n),
      .i_dbus_valid(i_dbus_valid), .i_dbus_addr(i_dbus_addr),
      .i_dbus_wdata(i_dbus_wdata), .i_dbus_wstrb(i_dbus_wstrb),
      .o_dbus_rdata(o_dbus_rdata), .o_dbus_ready(o_dbus_ready),
      .o_mem_valid(dm_valid), .o_mem_addr(dm_addr),
      .o_mem_wdata(dm_wdata), .o_mem_wstrb(dm_wstrb),
      .i_mem_rdata(dm_rdata), .i_mem_ready(dm_ready),
      .o_reg_valid(reg_valid), .o_reg_wdata(reg_wdata), .o_reg_wstrb(reg_wstrb),
      .i_reg_rdata(reg_rdata), .i_reg_ready(reg_ready)
   );

   boot_ctrl i_boot_ctrl (
      .i_clk(i_clk), .i_rst_n(i_rst_n),
      .o_boot(o_boot), .o_cpu_reset(o_cpu_reset),
      .i_reg_valid(reg_valid), .i_reg_wdata(reg_wdata), .i_reg_wstrb(reg_wstrb),
      .o_reg_rdata(reg_rdata), .o_reg_ready(reg_ready),
      .o_bw_valid(bw_valid), .o_bw_addr(bw_addr),
      .o_bw_wdata(bw_wdata), .o_bw_wstrb(bw_wstrb), .i_bw_ready(bw_ready)
   );

   // instruction bus is read only
   bus_merge i_merge (
      .i_clk(i_clk), .i_rst_n(i_rst_n),
      .i_bw_valid(bw_valid), .i_bw_addr(bw_addr),
      .i_bw_wdata(bw_wdata), .i_bw_wstrb(bw_wstrb), .o_bw_ready(bw_ready),
      .i_cpu_valid(i_ibus_valid), .i_cpu_addr(i_word),
      .i_cpu_wdata('0), .i_cpu_wstrb('0),
      .o_cpu_rdata(o_ibus_rdata), .o_cpu_ready(o_ibus_ready),
      .o_mem_valid(im_valid), .o_mem_addr(im_addr),
      .o_mem_wdata(im_wdata), .o_mem_wstrb(im_wstrb),
      .i_mem_rdata(im_rdata), .i_mem_ready(im_ready)
   );

   dual_port_sram i_sram (
      .i_clk(i_clk),
      .i_i_valid(im_valid), .i_i_addr(im_addr),
      .i_i_wdata(im_wdata), .i_i_wstrb(im_wstrb),
      .o_i_rdata(im_rdata), .o_i_ready(im_ready),
      .i_d_valid(dm_valid), .i_d_addr(dm_word),
      .i_d_wdata(dm_wdata), .i_d_wstrb(dm_wstrb),
      .o_d_rdata(dm_rdata), .o_d_ready(dm_ready)
   );

endmodule

// File: design/mem_cfg_pkg.sv
package mem_cfg_pkg;

   // bus widths
   localparam int DATA_W = 32;
   localparam int ADDR_W = 32;
   localparam int STRB_W = DATA_W / 8;

   // sram is 1 KiB, 256 words
   localparam int SRAM_ADDR_W = 10;
   localparam int SRAM_WORD_AW = SRAM_ADDR_W - 2;
   localparam int SRAM_WORDS = 2 ** SRAM_WORD_AW;

   // boot image, 64 bytes at the top of the sram
   localparam int BOOTROM_ADDR_W = 6;
   localparam int BOOT_WORDS = 2 ** (BOOTROM_ADDR_W - 2);

   // word offset added to every address while in boot mode
   localparam int BOOT_OFFSET_W = SRAM_WORDS - BOOT_WORDS;

   // dbus address bit that selects the boot register
   localparam int REG_SEL_BIT = 31;

endpackage

// File: filelist.f
design/mem_cfg_pkg.sv
design/boot_pkg.sv
design/dual_port_sram.sv
design/bus_merge.sv
design/bus_split.sv
design/boot_ctrl.sv
design/int_mem.sv
test/int_mem_asserts.sv
test/int_mem_tb.sv

// File: test/int_mem_asserts.sv
`timescale 1ns/1ps

module int_mem_asserts import mem_cfg_pkg::*; import boot_pkg::*; (
   input logic                    i_clk,
   input logic                    i_rst_n,
   input logic                    i_im_valid,
   input logic                    i_im_ready,
   input logic [SRAM_WORD_AW-1:0] i_im_addr,
   input logic [STRB_W-1:0]       i_im_wstrb,
   input logic                    i_dm_valid,
   input logic                    i_dm_ready,
   input merge_src_t              i_merge_grant
);

   int fail_cnt = 0;

   // sram answers one cycle after a fresh request on both ports
   im_ready_after_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_im_valid && !i_im_ready |=> i_im_ready)
      else begin
         fail_cnt++;
         $error("sram instruction port ready did not follow valid");
      end

   dm_ready_after_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_dm_valid && !i_dm_ready |=> i_dm_ready)
      else begin
         fail_cnt++;
         $error("sram data port ready did not follow valid");
      end

   // no response without a request in the cycle before
   im_ready_has_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_im_ready |-> $past(i_im_valid))
      else begin
         fail_cnt++;
         $error("sram instruction port ready without a request");
      end

   dm_ready_has_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_dm_ready |-> $past(i_dm_valid))
      else begin
         fail_cnt++;
         $error("sram data port ready without a request");
      end

   // granted source keeps the sram port until it answers
   // only the boot stream writes through the merge
   grant_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_im_valid && !i_im_ready |=> $stable(i_im_addr) && $stable(i_im_wstrb)
         && i_merge_grant == ((i_im_wstrb != '0) ? SRC_BOOT : SRC_CPU))
      else begin
         fail_cnt++;
         $error("merge grant changed while a request was pending");
      end

endmodule

// File: test/int_mem_tb.sv
`timescale 1ns/1ps

module int_mem_tb import mem_cfg_pkg::*; ();

   localparam int TIMEOUT_CYC = 5000;
   localparam int PULSE_CYC = 4;
   localparam int DATA_WORDS = 8;
   localparam logic [ADDR_W-1:0] REG_ADDR = ADDR_W'(1) << REG_SEL_BIT;

   logic              clk;
   logic              rst_n;
   logic              boot;
   logic              cpu_reset;
   logic              ibus_valid;
   logic [ADDR_W-1:0] ibus_addr;
   logic [DATA_W-1:0] ibus_rdata;
   logic              ibus_ready;
   logic              dbus_valid;
   logic [ADDR_W-1:0] dbus_addr;
   logic [DATA_W-1:0] dbus_wdata;
   logic [STRB_W-1:0] dbus_wstrb;
   logic [DATA_W-1:0] dbus_rdata;
   logic              dbus_ready;

   // reference model of the sram and the boot bit
   logic [DATA_W-1:0] model [SRAM_WORDS];
   logic [DATA_W-1:0] boot_img [BOOT_WORDS];
   logic              exp_boot;
   int                seed = 49294;
   int                cycles = 0;

   int_mem i_dut (
      .i_clk(clk), .i_rst_n(rst_n), .o_boot(boot), .o_cpu_reset(cpu_reset),
      .i_ibus_valid(ibus_valid), .i_ibus_addr(ibus_addr),
      .o_ibus_rdata(ibus_rdata), .o_ibus_ready(ibus_ready),
      .i_dbus_valid(dbus_valid), .i_dbus_addr(dbus_addr),
      .i_dbus_wdata(dbus_wdata), .i_dbus_wstrb(dbus_wstrb),
      .o_dbus_rdata(dbus_rdata), .o_dbus_ready(dbus_ready)
   );

   bind int_mem int_mem_asserts i_asserts (
      .i_clk(i_clk), .i_rst_n(i_rst_n),
      .i_im_valid(im_valid), .i_im_ready(im_ready),
      .i_im_addr(im_addr), .i_im_wstrb(im_wstrb),
      .i_dm_valid(dm_valid), .i_dm_ready(dm_ready),
      .i_merge_grant(i_merge.grant)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic stop_with_fail();
      $display("=== FAIL ===");
      $fatal(1, "run stopped at cycle %0d", cycles);
   endtask

   // full run is a few hundred cycles
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles == TIMEOUT_CYC) begin
         $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYC);
         stop_with_fail();
      end
   end

   always @(negedge clk) begin
      if (i_dut.i_asserts.fail_cnt != 0) begin
         $display("a protocol assertion failed");
         stop_with_fail();
      end
   end

   // boot mode moves the word address up by the offset and wraps in the sram
   function automatic int sram_word(input logic [ADDR_W-1:0] addr, input logic in_boot);
      int w;
      w = int'(addr[SRAM_ADDR_W-1:2]);
      if (in_boot) begin
         w = w + BOOT_OFFSET_W;
      end
      return w % SRAM_WORDS;
   endfunction

   task automatic ibus_read(input logic [ADDR_W-1:0] addr);
      logic [DATA_W-1:0] exp;
      logic [DATA_W-1:0] got;
      @(negedge clk);
      exp = model[sram_word(addr, exp_boot)];
      ibus_valid = 1'b1;
      ibus_addr = addr;
      do begin
         @(negedge clk);
      end while (!ibus_ready);
      got = ibus_rdata;
      ibus_valid = 1'b0;
      assert (got === exp) else begin
         $display("[ERROR] o_ibus_rdata at %08h: got %08h, expected %08h", addr, got, exp);
         stop_with_fail();
      end
   endtask

   // one dbus handshake that returns on the ready cycle
   task automatic dbus_xfer(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                            input logic [STRB_W-1:0] wstrb, output logic [DATA_W-1:0] rdata);
      @(negedge clk);
      dbus_valid = 1'b1;
      dbus_addr = addr;
      dbus_wdata = wdata;
      dbus_wstrb = wstrb;
      do begin
         @(negedge clk);
      end while (!dbus_ready);
      rdata = dbus_rdata;
      dbus_valid = 1'b0;
      dbus_wstrb = '0;
   endtask

   task automatic dbus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                             input logic [STRB_W-1:0] wstrb);
      int                w;
      logic [DATA_W-1:0] rdata;
      w = sram_word(addr, exp_boot);
      for (int b = 0; b < STRB_W; b++) begin
         if (wstrb[b]) begin
            model[w][8*b +: 8] = wdata[8*b +: 8];
         end
      end
      dbus_xfer(addr, wdata, wstrb, rdata);
      @(negedge clk);
      assert (!dbus_ready) else begin
         $display("dbus ready stayed high after the write at %08h was accepted", addr);
         stop_with_fail();
      end
   endtask

   task automatic dbus_read(input logic [ADDR_W-1:0] addr);
      logic [DATA_W-1:0] exp;
      logic [DATA_W-1:0] got;
      if (addr[REG_SEL_BIT]) begin
         exp = {{(DATA_W-1){1'b0}}, exp_boot};
      end else begin
         exp = model[sram_word(addr, exp_boot)];
      end
      dbus_xfer(addr, '0, '0, got);
      assert (got === exp) else begin
         $display("[ERROR] o_dbus_rdata at %08h: got %08h, expected %08h", addr, got, exp);
         stop_with_fail();
      end
   endtask

   task automatic reg_write(input logic [DATA_W-1:0] wdata);
      logic              leaving;
      logic [DATA_W-1:0] rdata;
      int                pulse;
      leaving = exp_boot & ~wdata[0];
      if (leaving) begin
         exp_boot = 1'b0;
      end
      dbus_xfer(REG_ADDR, wdata, {STRB_W{1'b1}}, rdata);
      assert (boot === exp_boot) else begin
         $display("[ERROR] o_boot: got %0h, expected %0h", boot, exp_boot);
         stop_with_fail();
      end
      if (leaving) begin
         // cpu reset rises with the register ready
         pulse = 0;
         while (cpu_reset && pulse <= PULSE_CYC) begin
            pulse++;
            @(negedge clk);
         end
         assert (pulse == PULSE_CYC) else begin
            $display("[ERROR] o_cpu_reset cycles high: got %0h, expected %0h", pulse, PULSE_CYC);
            stop_with_fail();
         end
      end
   endtask

   task automatic copy_after_reset();
      assert (boot === 1'b1 && cpu_reset === 1'b1) else begin
         $display("[ERROR] o_boot/o_cpu_reset after reset: got %0h/%0h, expected 1/1",
                  boot, cpu_reset);
         stop_with_fail();
      end
      // fetch while the copy still owns the instruction port
      ibus_read(ADDR_W'(5 * 4));
      assert (cpu_reset === 1'b0) else begin
         $display("early fetch completed before the boot copy finished");
         stop_with_fail();
      end
      while (cpu_reset) begin
         @(negedge clk);
      end
   endtask

   task automatic fetch_boot_image();
      for (int i = 0; i < BOOT_WORDS; i++) begin
         ibus_read(ADDR_W'(i * 4));
      end
   endtask

   task automatic store_boot_data();
      logic [ADDR_W-1:0] addr;
      logic [STRB_W-1:0] strb;
      for (int i = 0; i < DATA_WORDS; i++) begin
         addr = ADDR_W'((BOOT_WORDS + i) * 4);
         dbus_write(addr, DATA_W'($random(seed)), {STRB_W{1'b1}});
         strb = STRB_W'($random(seed));
         if (strb == '0) begin
            strb = 4'h9;
         end
         dbus_write(addr, DATA_W'($random(seed)), strb);
      end
      for (int i = 0; i < DATA_WORDS; i++) begin
         dbus_read(ADDR_W'((BOOT_WORDS + i) * 4));
         ibus_read(ADDR_W'((BOOT_WORDS + i) * 4));
      end
   endtask

   task automatic leave_boot_mode();
      reg_write('0);
      dbus_read(REG_ADDR);
   endtask

   task automatic read_after_boot();
      for (int i = 0; i < BOOT_WORDS; i++) begin
         ibus_read(ADDR_W'((BOOT_OFFSET_W + i) * 4));
      end
      for (int i = 0; i < DATA_WORDS; i++) begin
         dbus_read(ADDR_W'(i * 4));
      end
   endtask

   initial begin
      rst_n = 1'b0;
      ibus_valid = 1'b0;
      ibus_addr = '0;
      dbus_valid = 1'b0;
      dbus_addr = '0;
      dbus_wdata = '0;
      dbus_wstrb = '0;
      exp_boot = 1'b1;
      $readmemh("boot_rom.hex", boot_img);
      for (int i = 0; i < BOOT_WORDS; i++) begin
         model[BOOT_OFFSET_W + i] = boot_img[i];
      end
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      copy_after_reset();
      fetch_boot_image();
      store_boot_data();
      leave_boot_mode();
      read_after_boot();
      @(negedge clk);
      if (i_dut.i_asserts.fail_cnt != 0) begin
         $display("a protocol assertion failed");
         stop_with_fail();
      end else begin
         $display("=== PASS ===");
         $finish;
      end
   end

endmodule
